// ==== design/chip_integrator.sv ====
module chip_integrator
  import correlator_pkg::*;
(
  input  logic        crx_clk,
  input  logic        rrx_rst,
  input  logic        en,
  input  logic        chip_valid,
  input  logic        symbol_end,
  input  sample_blk_t samples,
  output chip_sum_t   chip_s
);

  // each group is two pairs, so four samples, five groups in all
  localparam int N_GROUPS = N_PAIRS / 2;

  pair_t pair_q [N_PAIRS];   // stage 1
  acc_t  grp_q  [N_GROUPS];  // stage 2
  acc_t  sum_01_q;           // stage 3
  acc_t  sum_23_q;
  acc_t  sum_44_q;
  acc_t  sum_0123_q;         // stage 4
  acc_t  sum_444_q;
  acc_t  sum_q;              // stage 5

  logic [TREE_LAT-1:0] vld_sr;  // flags ride beside the data
  logic [TREE_LAT-1:0] lst_sr;

  // stage 1, pair pre-adders with sign extension
  always_ff @(posedge crx_clk) begin
    if (rrx_rst || !en) begin
      pair_q <= '{default: '0};
    end else begin
      for (int k = 0; k < N_PAIRS; k++) begin
        pair_q[k] <= {samples[k][SAMPLE_W-1], samples[k]} +
                     {samples[k+N_PAIRS][SAMPLE_W-1], samples[k+N_PAIRS]};
      end
    end
  end

  // stage 2, groups of four samples
  always_ff @(posedge crx_clk) begin
    if (rrx_rst || !en) begin
      grp_q <= '{default: '0};
    end else begin
      for (int g = 0; g < N_GROUPS; g++) begin
        grp_q[g] <= pair_q[2*g] + pair_q[2*g+1];  // widens to acc_t
      end
    end
  end

  // stages 3 and 4 pair off the groups, group 4 is carried along
  always_ff @(posedge crx_clk) begin
    if (rrx_rst || !en) begin
      sum_01_q   <= '0;
      sum_23_q   <= '0;
      sum_44_q   <= '0;
      sum_0123_q <= '0;
      sum_444_q  <= '0;
    end else begin
      sum_01_q   <= grp_q[0] + grp_q[1];
      sum_23_q   <= grp_q[2] + grp_q[3];
      sum_44_q   <= grp_q[4];
      sum_0123_q <= sum_01_q + sum_23_q;
      sum_444_q  <= sum_44_q;
    end
  end

  // stage 5, final chip value
  always_ff @(posedge crx_clk) begin
    if (rrx_rst || !en) begin
      sum_q <= '0;
    end else begin
      sum_q <= sum_0123_q + sum_444_q;
    end
  end

  // valid and last delay line, same depth as the tree
  always_ff @(posedge crx_clk) begin
    if (rrx_rst || !en) begin
      vld_sr <= '0;
      lst_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[TREE_LAT-2:0], chip_valid};
      lst_sr <= {lst_sr[TREE_LAT-2:0], symbol_end};
    end
  end

  assign chip_s.valid = vld_sr[TREE_LAT-1];
  assign chip_s.last  = lst_sr[TREE_LAT-1];
  assign chip_s.sum   = sum_q;

  // a symbol end only comes out if it went in while enabled
  a_last_from_input: assert property (
    @(posedge crx_clk) disable iff (rrx_rst)
      chip_s.last |-> $past(symbol_end && en, TREE_LAT)
  ) else $error("chip_s.last without an enabled symbol_end %0d cycles back", TREE_LAT);

endmodule

// ==== design/correlator_pkg.sv ====
package correlator_pkg;

  // input block geometry
  localparam int SAMPLE_W  = 16;  // adc sample width
  localparam int N_SAMPLES = 20;  // samples per chip
  localparam int N_PAIRS   = 10;  // sample k pairs with k+N_PAIRS
  localparam int PAIR_W    = 17;  // one bit of growth per pair

  // correlation side
  localparam int N_SEQ     = 16;  // candidate sequences, also lfsr width
  localparam int ACC_W     = 41;  // accumulator and tree width

  // strobe in to chip_s out, one pre-add stage plus four tree stages
  localparam int TREE_LAT  = 5;

  // fibonacci feedback taps at bits 15, 13, 12 and 10
  // x^16 + x^14 + x^13 + x^11 + 1
  localparam logic [N_SEQ-1:0] LFSR_TAPS = 16'hB400;

  // one raw sample
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // a whole chip block, all samples in one cycle
  typedef sample_t [N_SAMPLES-1:0] sample_blk_t;

  // pre-adder result
  typedef logic signed [PAIR_W-1:0] pair_t;

  // tree, accumulator and result word
  typedef logic signed [ACC_W-1:0] acc_t;

  // integrated chip plus its flags
  typedef struct packed {
    logic valid;      // sum holds a real chip
    logic last;       // symbol ends with this slot
    acc_t sum;        // integrated chip value
  } chip_sum_t;

  // one total per candidate sequence
  typedef acc_t [N_SEQ-1:0] corr_vec_t;

endpackage

// ==== design/correlator_top.sv ====
module correlator_top
  import correlator_pkg::*;
#(
  parameter logic [N_SEQ-1:0] LFSR_SEED = 16'hACE1  // any nonzero value
) (
  input  logic        crx_clk,
  input  logic        rrx_rst,
  input  logic        en,
  input  logic        chip_valid,
  input  logic        symbol_end,
  input  sample_blk_t samples,
  output corr_vec_t   corr,
  output logic        result_valid
);

  chip_sum_t        chip_s;    // integrated chip with flags
  logic [N_SEQ-1:0] seq_bits;  // current chip of each sequence

  // block of samples to one chip value
  chip_integrator u_chip_integrator (
    .crx_clk    (crx_clk),
    .rrx_rst    (rrx_rst),
    .en         (en),
    .chip_valid (chip_valid),
    .symbol_end (symbol_end),
    .samples    (samples),
    .chip_s     (chip_s)
  );

  // sequence generator, paced by the chips leaving the tree
  prbs_bank #(
    .LFSR_SEED (LFSR_SEED)
  ) u_prbs_bank (
    .crx_clk  (crx_clk),
    .rrx_rst  (rrx_rst),
    .en       (en),
    .chip_s   (chip_s),
    .seq_bits (seq_bits)
  );

  // sixteen correlations and the result strobe
  sequence_accumulator u_sequence_accumulator (
    .crx_clk      (crx_clk),
    .rrx_rst      (rrx_rst),
    .en           (en),
    .chip_s       (chip_s),
    .seq_bits     (seq_bits),
    .corr         (corr),
    .result_valid (result_valid)
  );

endmodule

// ==== design/prbs_bank.sv ====
module prbs_bank
  import correlator_pkg::*;
#(
  parameter logic [N_SEQ-1:0] LFSR_SEED = 16'hACE1
) (
  input  logic             crx_clk,
  input  logic             rrx_rst,
  input  logic             en,
  input  chip_sum_t        chip_s,
  output logic [N_SEQ-1:0] seq_bits
);

  logic [N_SEQ-1:0] lfsr_q;
  logic             fb;

  assign fb = ^(lfsr_q & LFSR_TAPS);  // xor of the tap bits

  // each bit is the current chip of one candidate sequence
  always_ff @(posedge crx_clk) begin
    if (rrx_rst || !en) begin
      lfsr_q <= LFSR_SEED;
    end else if (chip_s.last) begin
      lfsr_q <= LFSR_SEED;  // next symbol restarts all sequences
    end else if (chip_s.valid) begin
      lfsr_q <= {lfsr_q[N_SEQ-2:0], fb};  // shift up, feedback into bit 0
    end
  end

  assign seq_bits = lfsr_q;  // applies to this cycle's chip

  // all-zero state would lock the lfsr
  a_lfsr_nonzero: assert property (
    @(posedge crx_clk) disable iff (rrx_rst)
      lfsr_q != '0
  ) else $error("lfsr reached the all-zero state");

endmodule

// ==== design/sequence_accumulator.sv ====
module sequence_accumulator
  import correlator_pkg::*;
(
  input  logic             crx_clk,
  input  logic             rrx_rst,
  input  logic             en,
  input  chip_sum_t        chip_s,
  input  logic [N_SEQ-1:0] seq_bits,
  output corr_vec_t        corr,
  output logic             result_valid
);

  corr_vec_t acc_q;     // running totals
  corr_vec_t acc_next;  // totals including this cycle's chip
  acc_t      chip_val;

  // an empty symbol end carries no chip
  assign chip_val = chip_s.valid ? chip_s.sum : '0;

  // sequence bit 1 adds the chip, 0 subtracts it
  always_comb begin
    for (int i = 0; i < N_SEQ; i++) begin
      if (seq_bits[i]) begin
        acc_next[i] = acc_q[i] + chip_val;
      end else begin
        acc_next[i] = acc_q[i] - chip_val;
      end
    end
  end

  always_ff @(posedge crx_clk) begin
    if (rrx_rst || !en) begin
      acc_q <= '0;
    end else if (chip_s.last) begin
      acc_q <= '0;  // fresh start for the next symbol
    end else begin
      acc_q <= acc_next;
    end
  end

  // totals of the finished symbol
  always_ff @(posedge crx_clk) begin
    if (rrx_rst || !en) begin
      corr <= '0;
    end else if (chip_s.last) begin
      corr <= acc_next;  // includes the last chip itself
    end
  end

  always_ff @(posedge crx_clk) begin
    if (rrx_rst || !en) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= chip_s.last;  // one pulse per symbol end
    end
  end

  // two pulses in a row need two symbol ends in a row
  a_pulse_per_end: assert property (
    @(posedge crx_clk) disable iff (rrx_rst)
      result_valid && $past(result_valid) |-> $past(chip_s.last, 1) && $past(chip_s.last, 2)
  ) else $error("result_valid held without back-to-back symbol ends");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the correlator testbench with verilator

cd "$(dirname "$0")" || exit 1

mkdir -p build \
  && verilator --binary --timing --assert -Wno-fatal \
       --timescale 1ns/1ps \
       --top-module tb_correlator \
       -Mdir build/obj -o sim_correlator \
       -f tb.f \
  && ./build/obj/sim_correlator | tee build/sim.log \
  || { echo "build or simulation did not complete"; exit 1; }

grep -qx "STATUS: PASS" build/sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build/sim.log"; exit 1; }

// ==== tb.f ====
design/correlator_pkg.sv
design/chip_integrator.sv
design/prbs_bank.sv
design/sequence_accumulator.sv
design/correlator_top.sv
tests/clk_gen.sv
tests/tb_correlator.sv

// ==== tests/clk_gen.sv ====
module clk_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 5
) (
  output logic crx_clk,
  output logic rrx_rst
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    crx_clk = 1'b0;
    forever #(PERIOD_NS / 2.0) crx_clk = ~crx_clk;
  end

  // reset drops on a falling edge, like every other dut input
  initial begin
    rrx_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge crx_clk);
    @(negedge crx_clk);
    rrx_rst = 1'b0;
  end

endmodule

// ==== tests/tb_correlator.sv ====
module tb_correlator
  import correlator_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int               CLK_PERIOD   = 8;
  localparam int               RST_CYCLES   = 5;
  localparam int               RESULT_LAT   = 6;   // symbol_end in to result_valid out
  localparam logic [N_SEQ-1:0] SEED         = 16'hACE1;
  localparam int               N_RAND       = 6;   // random symbols in test 3
  localparam int               GAP          = 2;   // idle cycles between random symbols
  localparam int               FIXED_CYCLES = 66;  // tests 1, 2, 4, 5 and the drains

  logic        crx_clk;
  logic        rrx_rst;
  logic        en;
  logic        chip_valid;
  logic        symbol_end;
  sample_blk_t samples;
  corr_vec_t   corr;
  logic        result_valid;

  // reference model state
  logic [N_SEQ-1:0] m_lfsr;
  corr_vec_t        m_acc;
  corr_vec_t        exp_q [$];
  corr_vec_t        exp_head;
  logic             head_ok;
  logic             seen_end;
  logic [RESULT_LAT-1:0] pend_sr;  // enabled symbol ends on their way out

  logic [31:0] lcg_state;
  int          rand_len [N_RAND];
  int          budget;
  string       test_name;

  int reset_errs;
  int timing_errs;
  int total_errs;
  int enable_errs;

  clk_gen #(
    .PERIOD_NS  (CLK_PERIOD),
    .RST_CYCLES (RST_CYCLES)
  ) u_clk_gen (
    .crx_clk (crx_clk),
    .rrx_rst (rrx_rst)
  );

  correlator_top #(
    .LFSR_SEED (SEED)
  ) DUT (
    .crx_clk      (crx_clk),
    .rrx_rst      (rrx_rst),
    .en           (en),
    .chip_valid   (chip_valid),
    .symbol_end   (symbol_end),
    .samples      (samples),
    .corr         (corr),
    .result_valid (result_valid)
  );

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];  // upper bits are the better ones
  endfunction

  function automatic sample_blk_t random_block();
    sample_blk_t b;
    for (int k = 0; k < N_SAMPLES; k++) begin
      b[k] = lcg_next();
    end
    return b;
  endfunction

  // x^16 + x^14 + x^13 + x^11 + 1, shifted toward the msb
  function automatic logic [N_SEQ-1:0] lfsr_step(input logic [N_SEQ-1:0] s);
    return {s[N_SEQ-2:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic acc_t block_sum(input sample_blk_t blk);
    acc_t s;
    s = '0;
    for (int k = 0; k < N_SAMPLES; k++) begin
      s = s + acc_t'(blk[k]);
    end
    return s;
  endfunction

  // one falling edge of stimulus, the model follows the same rules
  task automatic drive(input logic en_v, input logic vld, input logic lst,
                       input sample_blk_t blk);
    acc_t csum;
    @(negedge crx_clk);
    en         = en_v;
    chip_valid = vld;
    symbol_end = lst;
    samples    = blk;
    if (!en_v) begin
      m_acc  = '0;
      m_lfsr = SEED;
    end else begin
      if (vld) begin
        csum = block_sum(blk);
        for (int i = 0; i < N_SEQ; i++) begin
          m_acc[i] = m_lfsr[i] ? m_acc[i] + csum : m_acc[i] - csum;
        end
      end
      if (lst) begin
        exp_q.push_back(m_acc);
        m_acc    = '0;
        m_lfsr   = SEED;
        seen_end = 1'b1;
      end else if (vld) begin
        m_lfsr = lfsr_step(m_lfsr);
      end
    end
  endtask

  task automatic idle(input int n);
    repeat (n) drive(1'b1, 1'b0, 1'b0, '0);
  endtask

  always @(posedge crx_clk) begin
    if (rrx_rst || !en) begin
      pend_sr <= '0;
    end else begin
      pend_sr <= {pend_sr[RESULT_LAT-2:0], symbol_end};
    end
    if (result_valid && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
    end
  end

  // head of the expected queue, settled half a cycle before use
  always @(negedge crx_clk) begin
    head_ok  <= exp_q.size() > 0;
    exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
  end

  a_reset_idle: assert property (
    @(posedge crx_clk) disable iff (rrx_rst)
      !seen_end |-> !result_valid && corr == '0
  ) else begin
    reset_errs++;
    $display("[ERROR] %s: corr expected 0 actual %h, result_valid expected 0 actual %0b",
             test_name, $sampled(corr), $sampled(result_valid));
  end

  a_pulse_timing: assert property (
    @(posedge crx_clk) disable iff (rrx_rst)
      result_valid == pend_sr[RESULT_LAT-1]
  ) else begin
    timing_errs++;
    $display("[ERROR] %s: result_valid expected %0b actual %0b",
             test_name, $sampled(pend_sr[RESULT_LAT-1]), $sampled(result_valid));
  end

  a_totals: assert property (
    @(posedge crx_clk) disable iff (rrx_rst)
      result_valid |-> head_ok && corr == exp_head
  ) else begin
    total_errs++;
    if (!$sampled(head_ok)) begin
      $display("%s: result_valid came with no symbol end waiting for it", test_name);
    end else begin
      $display("[ERROR] %s: corr expected %h actual %h",
               test_name, $sampled(exp_head), $sampled(corr));
    end
  end

  a_quiet_when_off: assert property (
    @(posedge crx_clk) disable iff (rrx_rst)
      !en |=> !result_valid
  ) else begin
    enable_errs++;
    $display("[ERROR] %s: result_valid expected 0 actual 1 after en low", test_name);
  end

  initial begin
    wait (budget > 0);
    #((budget + 50) * CLK_PERIOD);
    $display("watchdog: run went past %0d cycles without finishing", budget + 50);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    en          = 1'b1;
    chip_valid  = 1'b0;
    symbol_end  = 1'b0;
    samples     = '0;
    m_lfsr      = SEED;
    m_acc       = '0;
    seen_end    = 1'b0;
    lcg_state   = 32'd4;
    test_name   = "reset";
    reset_errs  = 0;
    timing_errs = 0;
    total_errs  = 0;
    enable_errs = 0;
    budget      = 0;

    // symbol lengths first, so the watchdog knows the run length
    for (int s = 0; s < N_RAND; s++) begin
      rand_len[s] = 1 + int'(lcg_next() % 16'd30);
    end
    begin
      int rand_cycles;
      rand_cycles = 0;
      for (int s = 0; s < N_RAND; s++) begin
        rand_cycles += rand_len[s] + GAP;
      end
      budget = RST_CYCLES + FIXED_CYCLES + rand_cycles;
    end

    @(negedge rrx_rst);
    idle(8);

    test_name = "single_chip";
    drive(1'b1, 1'b1, 1'b1, {N_SAMPLES{16'sd1}});  // chip sum of 20
    idle(10);

    test_name = "random_symbols";
    for (int s = 0; s < N_RAND; s++) begin
      for (int c = 0; c < rand_len[s]; c++) begin
        drive(1'b1, 1'b1, c == rand_len[s] - 1, random_block());
      end
      idle(GAP);
    end
    idle(8);

    test_name = "back_to_back";
    repeat (3) drive(1'b1, 1'b1, 1'b1, random_block());
    drive(1'b1, 1'b0, 1'b1, '0);  // empty end, all totals zero
    idle(8);

    test_name = "enable_clear";
    repeat (7) drive(1'b1, 1'b1, 1'b0, random_block());
    repeat (4) drive(1'b0, 1'b1, 1'b1, random_block());  // chips and ends ignored while off
    idle(1);
    for (int c = 0; c < 5; c++) begin
      drive(1'b1, 1'b1, c == 4, random_block());
    end
    idle(10);

    if (exp_q.size() != 0) begin
      total_errs++;
      $display("%0d expected results never came out of the DUT", exp_q.size());
    end

    $display("errors: reset %0d, timing %0d, totals %0d, enable %0d",
             reset_errs, timing_errs, total_errs, enable_errs);
    if (reset_errs + timing_errs + total_errs + enable_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
